// File: design/port_pkg.sv
package port_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////

    localparam int NUM_MASTERS = 3;
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;

    // index width for the round-robin pointer
    localparam int PTR_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // standard AHB-Lite transfer types
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic {
        ARB_FREE  = 1'b0,
        ARB_OWNED = 1'b1
    } arb_state_e;

    //////////////////////////////
    // bundles
    //////////////////////////////

    // address phase, 38 bits
    typedef struct packed {
        htrans_e             htrans;
        logic                hwrite;
        logic [2:0]          hsize;
        logic [ADDR_W-1:0]   haddr;
    } ahb_addr_t;

    // slave response, 34 bits
    typedef struct packed {
        logic [DATA_W-1:0]   hrdata;
        logic                hresp;
        logic                hready;
    } ahb_rsp_t;

    // one bit per master, bit i is master i
    typedef logic [NUM_MASTERS-1:0] mst_vec_t;

    typedef logic [PTR_W-1:0] ptr_t;

endpackage

// File: design/rr_priority.sv
`timescale 1ns/1ps

module rr_priority (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  port_pkg::mst_vec_t  req_i,
    input  logic                grant_take_i,
    output port_pkg::mst_vec_t  winner_o
);

    port_pkg::ptr_t ptr_q;
    port_pkg::ptr_t win_idx;
    logic           win_found;

    // step an index forward with wrap at the master count
    function automatic port_pkg::ptr_t wrap_idx(
        input port_pkg::ptr_t base,
        input int unsigned    ofs
    );
        int unsigned sum;
        sum = (int'(base) + ofs) % port_pkg::NUM_MASTERS;
        return port_pkg::ptr_t'(sum);
    endfunction

    //////////////////////////////
    // winner select
    //////////////////////////////

    // scan from the pointer, the first requester wins
    always_comb begin
        winner_o  = '0;
        win_idx   = ptr_q;
        win_found = 1'b0;
        for (int k = 0; k < port_pkg::NUM_MASTERS; k++) begin
            if (!win_found && req_i[wrap_idx(ptr_q, k)]) begin
                win_idx   = wrap_idx(ptr_q, k);
                win_found = 1'b1;
            end
        end
        if (win_found) begin
            winner_o[win_idx] = 1'b1;
        end
    end

    //////////////////////////////
    // pointer update
    //////////////////////////////

    // the master just served drops to lowest priority
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            ptr_q <= '0;
        end else if (grant_take_i && win_found) begin
            ptr_q <= wrap_idx(win_idx, 1);
        end
    end

endmodule

// File: design/arb_ctrl.sv
`timescale 1ns/1ps

module arb_ctrl (
    input  logic                 HCLK,
    input  logic                 HRESETn,
    input  port_pkg::ahb_addr_t  mst_addr_i [port_pkg::NUM_MASTERS],
    input  logic                 slv_hready_i,
    input  port_pkg::mst_vec_t   winner_i,
    output port_pkg::mst_vec_t   req_o,
    output logic                 grant_take_o,
    output port_pkg::mst_vec_t   addr_grant_o,
    output port_pkg::mst_vec_t   data_owner_o
);

    port_pkg::arb_state_e state;
    port_pkg::arb_state_e state_nxt;
    port_pkg::mst_vec_t   grant_nxt;
    port_pkg::mst_vec_t   owner_nxt;
    port_pkg::mst_vec_t   xfer;
    logic                 owner_idle;
    logic                 granted_xfer;

    //////////////////////////////
    // request decode
    //////////////////////////////

    // any non-IDLE htrans is a request, only NONSEQ/SEQ open a data phase
    always_comb begin
        for (int i = 0; i < port_pkg::NUM_MASTERS; i++) begin
            req_o[i] = (mst_addr_i[i].htrans != port_pkg::HTRANS_IDLE);
            xfer[i]  = (mst_addr_i[i].htrans == port_pkg::HTRANS_NONSEQ) ||
                       (mst_addr_i[i].htrans == port_pkg::HTRANS_SEQ);
        end
    end

    // grant is one-hot, so masking is enough to look at the owner
    assign owner_idle   = ~|(addr_grant_o & req_o);
    assign granted_xfer = |(addr_grant_o & xfer);

    // rr_priority rotates on this pulse
    assign grant_take_o = (state == port_pkg::ARB_FREE) && (|req_o);

    //////////////////////////////
    // grant FSM
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        grant_nxt = addr_grant_o;
        case (state)
            port_pkg::ARB_FREE: begin
                if (grant_take_o) begin
                    state_nxt = port_pkg::ARB_OWNED;
                    grant_nxt = winner_i;
                end
            end
            port_pkg::ARB_OWNED: begin
                // release only once the owner has gone IDLE and the slave is ready
                if (slv_hready_i && owner_idle) begin
                    state_nxt = port_pkg::ARB_FREE;
                    grant_nxt = '0;
                end
            end
        endcase
    end

    // data phase follows the accepted address phase
    assign owner_nxt = granted_xfer ? addr_grant_o : '0;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state        <= port_pkg::ARB_FREE;
            addr_grant_o <= '0;
            data_owner_o <= '0;
        end else begin
            state        <= state_nxt;
            addr_grant_o <= grant_nxt;
            // wait states hold the current data phase
            if (slv_hready_i) begin
                data_owner_o <= owner_nxt;
            end
        end
    end

endmodule

// File: design/master_mux.sv
`timescale 1ns/1ps

module master_mux (
    input  port_pkg::ahb_addr_t       mst_addr_i   [port_pkg::NUM_MASTERS],
    input  logic [port_pkg::DATA_W-1:0] mst_hwdata_i [port_pkg::NUM_MASTERS],
    input  port_pkg::mst_vec_t        addr_grant_i,
    input  port_pkg::mst_vec_t        data_owner_i,
    output port_pkg::ahb_addr_t       slv_addr_o,
    output logic [port_pkg::DATA_W-1:0] slv_hwdata_o
);

    //////////////////////////////
    // address phase
    //////////////////////////////

    // no grant means the slave sees an IDLE transfer
    always_comb begin
        slv_addr_o        = '0;
        slv_addr_o.htrans = port_pkg::HTRANS_IDLE;
        for (int i = 0; i < port_pkg::NUM_MASTERS; i++) begin
            if (addr_grant_i[i]) begin
                slv_addr_o = mst_addr_i[i];
            end
        end
    end

    //////////////////////////////
    // write data
    //////////////////////////////

    // hwdata belongs to the data phase, so it follows the owner and not the grant
    always_comb begin
        slv_hwdata_o = '0;
        for (int i = 0; i < port_pkg::NUM_MASTERS; i++) begin
            if (data_owner_i[i]) begin
                slv_hwdata_o = mst_hwdata_i[i];
            end
        end
    end

endmodule

// File: design/response_router.sv
`timescale 1ns/1ps

module response_router (
    input  port_pkg::ahb_addr_t  mst_addr_i [port_pkg::NUM_MASTERS],
    input  port_pkg::ahb_rsp_t   slv_rsp_i,
    input  port_pkg::mst_vec_t   addr_grant_i,
    input  port_pkg::mst_vec_t   data_owner_i,
    output port_pkg::ahb_rsp_t   mst_rsp_o  [port_pkg::NUM_MASTERS]
);

    port_pkg::mst_vec_t req;
    port_pkg::mst_vec_t on_bus;

    always_comb begin
        for (int i = 0; i < port_pkg::NUM_MASTERS; i++) begin
            req[i]    = (mst_addr_i[i].htrans != port_pkg::HTRANS_IDLE);
            on_bus[i] = addr_grant_i[i] | data_owner_i[i];
        end
    end

    //////////////////////////////
    // per-master response
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < port_pkg::NUM_MASTERS; i++) begin
            // read data and error only reach the data owner
            mst_rsp_o[i].hrdata = data_owner_i[i] ? slv_rsp_i.hrdata : '0;
            mst_rsp_o[i].hresp  = data_owner_i[i] ? slv_rsp_i.hresp : 1'b0;

            // a waiting requester is stalled, an idle master sees ready
            if (on_bus[i]) begin
                mst_rsp_o[i].hready = slv_rsp_i.hready;
            end else begin
                mst_rsp_o[i].hready = ~req[i];
            end
        end
    end

endmodule

// File: design/ahb_master_port.sv
`timescale 1ns/1ps

module ahb_master_port (
    input  logic                        HCLK,
    input  logic                        HRESETn,
    input  port_pkg::ahb_addr_t         mst_addr_i   [port_pkg::NUM_MASTERS],
    input  logic [port_pkg::DATA_W-1:0] mst_hwdata_i [port_pkg::NUM_MASTERS],
    output port_pkg::ahb_rsp_t          mst_rsp_o    [port_pkg::NUM_MASTERS],
    output port_pkg::ahb_addr_t         slv_addr_o,
    output logic [port_pkg::DATA_W-1:0] slv_hwdata_o,
    input  port_pkg::ahb_rsp_t          slv_rsp_i
);

    port_pkg::mst_vec_t req;
    port_pkg::mst_vec_t winner;
    port_pkg::mst_vec_t addr_grant;
    port_pkg::mst_vec_t data_owner;
    logic               grant_take;

    //////////////////////////////
    // control
    //////////////////////////////

    arb_ctrl u_arb_ctrl (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .mst_addr_i   (mst_addr_i),
        .slv_hready_i (slv_rsp_i.hready),
        .winner_i     (winner),
        .req_o        (req),
        .grant_take_o (grant_take),
        .addr_grant_o (addr_grant),
        .data_owner_o (data_owner)
    );

    rr_priority u_rr_priority (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .req_i        (req),
        .grant_take_i (grant_take),
        .winner_o     (winner)
    );

    //////////////////////////////
    // datapath
    //////////////////////////////

    master_mux u_master_mux (
        .mst_addr_i   (mst_addr_i),
        .mst_hwdata_i (mst_hwdata_i),
        .addr_grant_i (addr_grant),
        .data_owner_i (data_owner),
        .slv_addr_o   (slv_addr_o),
        .slv_hwdata_o (slv_hwdata_o)
    );

    response_router u_response_router (
        .mst_addr_i   (mst_addr_i),
        .slv_rsp_i    (slv_rsp_i),
        .addr_grant_i (addr_grant),
        .data_owner_i (data_owner),
        .mst_rsp_o    (mst_rsp_o)
    );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic HCLK,
    output logic HRESETn
);

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 10;

    initial begin
        HCLK = 1'b0;
        forever #(PERIOD_NS / 2) HCLK = ~HCLK;
    end

    // release a little after the edge, like every other driven input
    initial begin
        HRESETn = 1'b0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        #2 HRESETn = 1'b1;
    end

endmodule

// File: tb/tb_mem_slave.sv
`timescale 1ns/1ps

module tb_mem_slave (
    input  logic                        HCLK,
    input  logic                        HRESETn,
    input  port_pkg::ahb_addr_t         addr_i,
    input  logic [port_pkg::DATA_W-1:0] hwdata_i,
    output port_pkg::ahb_rsp_t          rsp_o
);

    localparam int DEPTH = 64;

    logic [port_pkg::DATA_W-1:0] mem [DEPTH];
    logic                        dp_active;
    logic                        dp_write;
    logic [5:0]                  dp_addr;
    logic                        wait_q;
    logic [1:0]                  phase_cnt;
    logic                        xfer;

    // every word gets its own start value
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'hA5A5_0000 | 32'(i);
        end
    end

    assign xfer = (addr_i.htrans == port_pkg::HTRANS_NONSEQ) ||
                  (addr_i.htrans == port_pkg::HTRANS_SEQ);

    always_comb begin
        rsp_o.hready = ~wait_q;
        rsp_o.hresp  = 1'b0;
        rsp_o.hrdata = (dp_active && !dp_write) ? mem[dp_addr] : '0;
    end

    // third data phase in a row gets one wait state
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            dp_active <= 1'b0;
            dp_write  <= 1'b0;
            dp_addr   <= '0;
            wait_q    <= 1'b0;
            phase_cnt <= '0;
        end else if (wait_q) begin
            wait_q <= 1'b0;
        end else begin
            dp_active <= xfer;
            dp_write  <= addr_i.hwrite;
            dp_addr   <= addr_i.haddr[7:2];
            if (xfer) begin
                wait_q    <= (phase_cnt == 2'd2);
                phase_cnt <= (phase_cnt == 2'd2) ? 2'd0 : phase_cnt + 2'd1;
            end
        end
    end

    // write lands when the data phase completes
    always @(posedge HCLK) begin
        if (HRESETn && !wait_q && dp_active && dp_write) begin
            mem[dp_addr] = hwdata_i;
        end
    end

endmodule

// File: tb/port_assertions.sv
`timescale 1ns/1ps

module port_assertions (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  port_pkg::arb_state_e  state_i,
    input  port_pkg::mst_vec_t    req_i,
    input  port_pkg::mst_vec_t    addr_grant_i,
    input  port_pkg::mst_vec_t    data_owner_i
);

    grant_onehot: assert property (
        @(posedge HCLK) disable iff (!HRESETn) $onehot0(addr_grant_i)
    ) else $error("addr_grant is neither zero nor one-hot");

    owner_onehot: assert property (
        @(posedge HCLK) disable iff (!HRESETn) $onehot0(data_owner_i)
    ) else $error("data_owner is neither zero nor one-hot");

    // an owner that still requests keeps the bus
    grant_held: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (state_i == port_pkg::ARB_OWNED && |(addr_grant_i & req_i)) |=> $stable(addr_grant_i)
    ) else $error("addr_grant changed while the owner was still requesting");

endmodule

bind arb_ctrl port_assertions u_port_assertions (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .state_i      (state),
    .req_i        (req_o),
    .addr_grant_i (addr_grant_o),
    .data_owner_i (data_owner_o)
);

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int NUM_M         = port_pkg::NUM_MASTERS;
    localparam int NUM_ENTRIES   = 16;
    localparam int CLK_PERIOD_NS = 40;
    localparam int WATCHDOG_NS   = (10 + NUM_ENTRIES * NUM_M * 20) * CLK_PERIOD_NS;

    // one row of the table, index [m] belongs to master m
    typedef struct packed {
        logic [NUM_M-1:0]                       mask;
        logic [NUM_M-1:0]                       write;
        logic [NUM_M-1:0][port_pkg::ADDR_W-1:0] addr;
        logic [NUM_M-1:0][port_pkg::DATA_W-1:0] wdata;
        logic [NUM_M-1:0][port_pkg::DATA_W-1:0] exp_rdata;
    } entry_t;

    logic                        HCLK;
    logic                        HRESETn;
    port_pkg::ahb_addr_t         mst_addr   [NUM_M];
    logic [port_pkg::DATA_W-1:0] mst_hwdata [NUM_M];
    port_pkg::ahb_rsp_t          mst_rsp    [NUM_M];
    port_pkg::ahb_addr_t         slv_addr;
    logic [port_pkg::DATA_W-1:0] slv_hwdata;
    port_pkg::ahb_rsp_t          slv_rsp;

    entry_t      stim_table [NUM_ENTRIES];
    logic [31:0] shadow_mem [64];
    logic [31:0] rng_state;
    int          grant_log [$];
    int          err_cnt;
    int          tests_run;
    int          tests_failed;
    int          busy_master;
    int          rr_ptr;
    int          wait_cycles = 0;

    tb_clock_gen u_clock_gen (.HCLK(HCLK), .HRESETn(HRESETn));

    ahb_master_port u_ahb_master_port (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .mst_addr_i   (mst_addr),
        .mst_hwdata_i (mst_hwdata),
        .mst_rsp_o    (mst_rsp),
        .slv_addr_o   (slv_addr),
        .slv_hwdata_o (slv_hwdata),
        .slv_rsp_i    (slv_rsp)
    );

    tb_mem_slave u_mem_slave (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .addr_i   (slv_addr),
        .hwdata_i (slv_hwdata),
        .rsp_o    (slv_rsp)
    );

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic void set_xfer(input int e, input int m, input logic wr, input int word);
        stim_table[e].mask[m]  = 1'b1;
        stim_table[e].write[m] = wr;
        stim_table[e].addr[m]  = 32'(word * 4);
        if (wr) begin
            rng_state                = xorshift32(rng_state);
            stim_table[e].wdata[m]   = rng_state;
            shadow_mem[word]         = rng_state;
        end else begin
            stim_table[e].exp_rdata[m] = shadow_mem[word];
        end
    endfunction

    // master m works in words 16*m and up, so masters never share an address
    function automatic void build_table();
        int e;
        e = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) stim_table[i] = '0;
        for (int k = 0; k < 4; k++) begin
            set_xfer(e, 0, 1'b1, k);
            e++;
        end
        for (int k = 0; k < 4; k++) begin
            set_xfer(e, 0, 1'b0, k);
            e++;
        end
        for (int r = 0; r < 6; r++) begin
            for (int m = 0; m < NUM_M; m++) set_xfer(e, m, r < 3, 16 * m + 4 + r % 3);
            e++;
        end
        set_xfer(e, 1, 1'b1, 24);
        set_xfer(e, 2, 1'b0, 36);
        e++;
        set_xfer(e, 0, 1'b0, 2);
        set_xfer(e, 2, 1'b1, 41);
    endfunction

    //////////////////////////////
    // checks and drivers
    //////////////////////////////

    task automatic check_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s got=%h exp=%h", $time, sig, got, exp);
            err_cnt++;
        end
    endtask

    task automatic run_master(input int m, input entry_t ent);
        logic ready;
        #2;
        mst_addr[m].htrans = port_pkg::HTRANS_NONSEQ;
        mst_addr[m].hwrite = ent.write[m];
        mst_addr[m].hsize  = 3'd2;
        mst_addr[m].haddr  = ent.addr[m];
        // hold the address phase, another owner must keep us stalled
        ready = 1'b0;
        while (!ready) begin
            @(negedge HCLK);
            ready = mst_rsp[m].hready;
            if (busy_master >= 0 && busy_master != m) begin
                assert (!ready) else begin
                    $display("master %0d was not stalled while master %0d held the bus",
                             m, busy_master);
                    err_cnt++;
                end
            end
        end
        @(posedge HCLK);
        assert (busy_master < 0) else begin
            $display("master %0d got the bus during the data phase of master %0d",
                     m, busy_master);
            err_cnt++;
        end
        busy_master = m;
        grant_log.push_back(m);
        #2;
        mst_addr[m]   = '0;
        mst_hwdata[m] = ent.write[m] ? ent.wdata[m] : '0;
        ready = 1'b0;
        while (!ready) begin
            @(negedge HCLK);
            ready = mst_rsp[m].hready;
            // the data owner shares every slave wait state
            check_word($sformatf("mst_rsp_o[%0d].hready", m), 32'(ready), 32'(slv_rsp.hready));
            if (!ready) wait_cycles++;
        end
        check_word($sformatf("mst_rsp_o[%0d].hresp", m), 32'(mst_rsp[m].hresp), 32'd0);
        if (!ent.write[m]) begin
            check_word($sformatf("mst_rsp_o[%0d].hrdata", m), mst_rsp[m].hrdata, ent.exp_rdata[m]);
        end
        for (int i = 0; i < NUM_M; i++) begin
            if (i != m) check_word($sformatf("mst_rsp_o[%0d].hrdata", i), mst_rsp[i].hrdata, '0);
        end
        @(posedge HCLK);
        busy_master = -1;
    endtask

    // the master just served goes to the back of the line
    task automatic check_grant_order(input int e, input logic [NUM_M-1:0] mask);
        logic [NUM_M-1:0] pending;
        int               exp_m;
        int               got_m;
        pending = mask;
        while (pending != '0) begin
            exp_m = -1;
            for (int k = 0; k < NUM_M; k++) begin
                if (exp_m < 0 && pending[(rr_ptr + k) % NUM_M]) exp_m = (rr_ptr + k) % NUM_M;
            end
            pending[exp_m] = 1'b0;
            rr_ptr = (exp_m + 1) % NUM_M;
            got_m = (grant_log.size() > 0) ? grant_log.pop_front() : -1;
            assert (got_m == exp_m) else begin
                $display("entry %0d granted master %0d where master %0d was next in turn",
                         e, got_m, exp_m);
                err_cnt++;
            end
        end
        grant_log.delete();
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            $display("test %-28s ok", name);
        end else begin
            tests_failed++;
            $display("test %-28s failed with %0d errors", name, err_cnt - err_before);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int err_before;
        for (int i = 0; i < NUM_M; i++) begin
            mst_addr[i]   = '0;
            mst_hwdata[i] = '0;
        end
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        busy_master  = -1;
        rr_ptr       = 0;
        rng_state    = 32'h80c3_0144;
        build_table();

        @(posedge HRESETn);
        @(posedge HCLK);
        err_before = err_cnt;
        @(negedge HCLK);
        for (int i = 0; i < NUM_M; i++) begin
            check_word($sformatf("mst_rsp_o[%0d].hready", i), 32'(mst_rsp[i].hready), 32'd1);
        end
        check_word("slv_addr_o.htrans", 32'(slv_addr.htrans), 32'(port_pkg::HTRANS_IDLE));
        report_test("idle after reset", err_before);
        @(posedge HCLK);

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            err_before = err_cnt;
            fork
                if (stim_table[e].mask[0]) run_master(0, stim_table[e]);
                if (stim_table[e].mask[1]) run_master(1, stim_table[e]);
                if (stim_table[e].mask[2]) run_master(2, stim_table[e]);
            join
            check_grant_order(e, stim_table[e].mask);
            report_test($sformatf("entry %0d masters %b", e, stim_table[e].mask), err_before);
        end

        err_before = err_cnt;
        assert (wait_cycles > 0) else begin
            $display("no master saw a wait state in its data phase during the run");
            err_cnt++;
        end
        report_test($sformatf("wait states seen %0d", wait_cycles), err_before);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: verilog.f
design/port_pkg.sv
design/rr_priority.sv
design/arb_ctrl.sv
design/master_mux.sv
design/response_router.sv
design/ahb_master_port.sv
tb/tb_clock_gen.sv
tb/tb_mem_slave.sv
tb/port_assertions.sv
tb/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
